//--- vlog.f
+incdir+design
design/graph_pkg.sv
design/sync_fifo.sv
design/rr_arbiter.sv
design/vertex_job_dispatch.sv
design/read_command_path.sv
design/vertex_worker.sv
design/graph_algorithm_control.sv
sim/tb_graph_control.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the graph control testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_graph_control -f vlog.f -o sim_graph_control

output=$(./obj_dir/sim_graph_control 2>&1) || true
echo "$output"

# Exit status follows the result of the search
echo "$output" | grep -q "TESTS PASSED"

//--- sim/tb_graph_control.sv
// Graph control testbench
`include "graph_consts.svh"

module tb_graph_control;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLOCK_PERIOD   = 20;
	localparam int RESET_CYCLES   = 10;
	localparam int NUM_JOBS       = 200;
	localparam int CYCLES_PER_JOB = 40;
	localparam int ACTIVE_CU      = 3;
	localparam int DRAIN_CYCLES   = 10;
	localparam int LFSR_SEED      = 93471;

	logic                   clock;
	logic                   rstn;
	logic                   enabled_in;
	logic [`CONFIG_W-1:0]   cu_configure;
	logic                   vertex_job_valid;
	graph_pkg::vertex_id_t  vertex_job_id;
	graph_pkg::edge_count_t vertex_job_edges;
	logic                   vertex_job_request;
	logic                   read_buffer_alfull;
	logic                   read_command_bus_grant;
	logic                   read_command_bus_request;
	logic                   read_command_valid;
	graph_pkg::vertex_id_t  read_command_address;
	graph_pkg::cu_id_t      read_command_cu_id;
	logic                   read_response_valid;
	graph_pkg::cu_id_t      read_response_cu_id;
	graph_pkg::counter_t    vertex_job_counter_done;
	graph_pkg::counter_t    edge_job_counter_done;

	// Model state
	logic [31:0]            lfsr_state;
	graph_pkg::vertex_id_t  sent_ids [$];
	graph_pkg::cu_id_t      pending_cu [$];
	int unsigned            pending_due [$];
	int unsigned            jobs_sent;
	int unsigned            commands_seen;
	int unsigned            responses_sent;
	int unsigned            cycle_count;
	longint unsigned        edge_sum_model;
	graph_pkg::counter_t    vertex_done_prev;
	graph_pkg::counter_t    edge_done_prev;
	logic                   alfull_prev;
	logic                   grant_prev1;
	logic                   grant_prev2;

	graph_algorithm_control UUT (
		.clock                   (clock),
		.rstn                    (rstn),
		.enabled_in              (enabled_in),
		.cu_configure            (cu_configure),
		.vertex_job_valid        (vertex_job_valid),
		.vertex_job_id           (vertex_job_id),
		.vertex_job_edges        (vertex_job_edges),
		.vertex_job_request      (vertex_job_request),
		.read_buffer_alfull      (read_buffer_alfull),
		.read_command_bus_grant  (read_command_bus_grant),
		.read_command_bus_request(read_command_bus_request),
		.read_command_valid      (read_command_valid),
		.read_command_address    (read_command_address),
		.read_command_cu_id      (read_command_cu_id),
		.read_response_valid     (read_response_valid),
		.read_response_cu_id     (read_response_cu_id),
		.vertex_job_counter_done (vertex_job_counter_done),
		.edge_job_counter_done   (edge_job_counter_done)
	);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	////////////////////////////////////////////////////////////
	// Random numbers and checking
	////////////////////////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	task automatic draw_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value      = {value[30:0], lfsr_state[0]};
		end
	endtask

	task automatic check_value(input string name, input longint unsigned expected,
		input longint unsigned actual);
		if (expected != actual) begin
			$display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
			$display("TESTS FAILED");
			$fatal(1, "stopping at the first error");
		end
	endtask

	////////////////////////////////////////////////////////////
	// Monitors
	////////////////////////////////////////////////////////////

	task automatic check_read_command();
		int          found;
		logic [31:0] delay;
		found = -1;
		for (int i = 0; i < sent_ids.size(); i++) begin
			if ((found < 0) && (sent_ids[i] == read_command_address)) begin
				found = i;
			end
		end
		check_value("read address was sent", 1, found >= 0);
		check_value("read cu id is active", 1, read_command_cu_id < ACTIVE_CU);
		sent_ids.delete(found);
		// Memory answers 1 to 8 cycles later
		draw_bits(3, delay);
		pending_cu.push_back(read_command_cu_id);
		pending_due.push_back(cycle_count + delay + 1);
		commands_seen++;
	endtask

	task automatic check_bus_and_counters();
		if (alfull_prev) begin
			check_value("bus request after alfull", 0, read_command_bus_request);
		end
		if (!grant_prev1 && !grant_prev2) begin
			check_value("read command without grant", 0, read_command_valid);
		end
		check_value("vertex done never decreases", 1,
			vertex_job_counter_done >= vertex_done_prev);
		check_value("edge done never decreases", 1, edge_job_counter_done >= edge_done_prev);
		check_value("vertex done within jobs sent", 1, vertex_job_counter_done <= jobs_sent);
		check_value("edge done within edge sum", 1, edge_job_counter_done <= edge_sum_model);
		vertex_done_prev = vertex_job_counter_done;
		edge_done_prev   = edge_job_counter_done;
		alfull_prev      = read_buffer_alfull;
		grant_prev2      = grant_prev1;
		grant_prev1      = read_command_bus_grant;
	endtask

	////////////////////////////////////////////////////////////
	// Drivers
	////////////////////////////////////////////////////////////

	task automatic drive_job();
		logic [31:0] gap;
		logic [31:0] id_bits;
		logic [31:0] edge_bits;
		vertex_job_valid <= 1'b0;
		if ((jobs_sent < NUM_JOBS) && vertex_job_request) begin
			draw_bits(2, gap);
			// Roughly one cycle in four stays empty
			if (gap != 0) begin
				draw_bits(`VERTEX_ID_W, id_bits);
				draw_bits(`EDGE_COUNT_W, edge_bits);
				vertex_job_valid <= 1'b1;
				vertex_job_id    <= graph_pkg::vertex_id_t'(id_bits);
				vertex_job_edges <= graph_pkg::edge_count_t'(edge_bits);
				sent_ids.push_back(graph_pkg::vertex_id_t'(id_bits));
				edge_sum_model += edge_bits;
				jobs_sent++;
			end
		end
	endtask

	task automatic drive_bus_levels();
		logic [31:0] grant_bits;
		logic [31:0] alfull_bits;
		draw_bits(2, grant_bits);
		draw_bits(2, alfull_bits);
		read_command_bus_grant <= (grant_bits != 0);
		read_buffer_alfull     <= (alfull_bits == 0);
	endtask

	task automatic drive_response();
		int due_index;
		due_index = -1;
		for (int i = 0; i < pending_due.size(); i++) begin
			if ((due_index < 0) && (pending_due[i] <= cycle_count)) begin
				due_index = i;
			end
		end
		read_response_valid <= 1'b0;
		// One response per cycle, the rest wait
		if (due_index >= 0) begin
			read_response_valid <= 1'b1;
			read_response_cu_id <= pending_cu[due_index];
			pending_cu.delete(due_index);
			pending_due.delete(due_index);
			responses_sent++;
		end
	endtask

	always @(posedge clock) begin
		if (rstn) begin
			if (read_command_valid) begin
				check_read_command();
			end
			check_bus_and_counters();
			drive_job();
			drive_bus_levels();
			drive_response();
			cycle_count++;
		end
	end

	////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////////////////////////

	initial begin
		clock                  = 1'b0;
		rstn                   = 1'b0;
		enabled_in             = 1'b0;
		cu_configure           = '0;
		vertex_job_valid       = 1'b0;
		vertex_job_id          = '0;
		vertex_job_edges       = '0;
		read_buffer_alfull     = 1'b0;
		read_command_bus_grant = 1'b0;
		read_response_valid    = 1'b0;
		read_response_cu_id    = '0;
		lfsr_state             = LFSR_SEED;
		jobs_sent              = 0;
		commands_seen          = 0;
		responses_sent         = 0;
		cycle_count            = 0;
		edge_sum_model         = 0;
		vertex_done_prev       = '0;
		edge_done_prev         = '0;
		alfull_prev            = 1'b0;
		grant_prev1            = 1'b0;
		grant_prev2            = 1'b0;

		repeat (RESET_CYCLES) @(posedge clock);
		rstn         <= 1'b1;
		enabled_in   <= 1'b1;
		cu_configure <= `CONFIG_W'(ACTIVE_CU);

		@(posedge clock);
		check_value("reset bus request", 0, read_command_bus_request);
		check_value("reset read command valid", 0, read_command_valid);
		check_value("reset vertex done", 0, vertex_job_counter_done);
		check_value("reset edge done", 0, edge_job_counter_done);
		check_value("reset job request", 1, vertex_job_request);

		wait (responses_sent == NUM_JOBS);
		repeat (DRAIN_CYCLES) @(posedge clock);
		check_value("read commands seen", NUM_JOBS, commands_seen);
		check_value("vertex jobs done", NUM_JOBS, vertex_job_counter_done);
		check_value("edges done", edge_sum_model, edge_job_counter_done);
		check_value("sent ids left unread", 0, sent_ids.size());
		$display("TESTS PASSED");
		$finish;
	end

	initial begin
		#((RESET_CYCLES + NUM_JOBS * CYCLES_PER_JOB) * CLOCK_PERIOD);
		$display("Timeout: %0d of %0d jobs finished before the time limit",
			responses_sent, NUM_JOBS);
		$display("TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- design/graph_algorithm_control.sv
// Graph algorithm control
`include "graph_consts.svh"

module graph_algorithm_control (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   enabled_in,
	input  logic [`CONFIG_W-1:0]   cu_configure,
	input  logic                   vertex_job_valid,
	input  graph_pkg::vertex_id_t  vertex_job_id,
	input  graph_pkg::edge_count_t vertex_job_edges,
	output logic                   vertex_job_request,
	input  logic                   read_buffer_alfull,
	input  logic                   read_command_bus_grant,
	output logic                   read_command_bus_request,
	output logic                   read_command_valid,
	output graph_pkg::vertex_id_t  read_command_address,
	output graph_pkg::cu_id_t      read_command_cu_id,
	input  logic                   read_response_valid,
	input  graph_pkg::cu_id_t      read_response_cu_id,
	output graph_pkg::counter_t    vertex_job_counter_done,
	output graph_pkg::counter_t    edge_job_counter_done
);

	logic                   enabled;
	logic [`CONFIG_W-1:0]   cu_configure_latched;
	graph_pkg::cu_mask_t    enable_mask_next;
	graph_pkg::cu_mask_t    enable_mask;
	logic                   response_valid_r;
	graph_pkg::cu_id_t      response_cu_id_r;
	graph_pkg::cu_mask_t    worker_response_valid;
	graph_pkg::cu_mask_t    worker_idle;
	graph_pkg::cu_mask_t    worker_job_valid;
	graph_pkg::vertex_id_t  worker_job_id;
	graph_pkg::edge_count_t worker_job_edges;
	graph_pkg::cu_mask_t    cmd_request;
	graph_pkg::cu_mask_t    cmd_grant;
	graph_pkg::vertex_id_t  cmd_address [`NUM_CU];
	graph_pkg::counter_t    vertex_count [`NUM_CU];
	graph_pkg::counter_t    edge_count [`NUM_CU];
	graph_pkg::counter_t    vertex_sum;
	graph_pkg::counter_t    edge_sum;

	////////////////////////////////////////////////////////////
	// Enable, configure and worker mask
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled              <= 1'b0;
			cu_configure_latched <= '0;
		end else begin
			enabled <= enabled_in;
			// A zero word leaves the old setting
			if (enabled && (|cu_configure)) begin
				cu_configure_latched <= cu_configure;
			end
		end
	end

	// Low field is the number of active workers
	always_comb begin
		for (int k = 0; k < `NUM_CU; k++) begin
			enable_mask_next[k] = (k < cu_configure_latched[`CU_COUNT_W-1:0]);
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enable_mask <= '0;
		end else if (enabled) begin
			enable_mask <= enable_mask_next;
		end
	end

	vertex_job_dispatch job_dispatch (
		.clock           (clock),
		.rstn            (rstn),
		.enabled         (enabled),
		.job_valid       (vertex_job_valid),
		.job_id          (vertex_job_id),
		.job_edges       (vertex_job_edges),
		.job_request     (vertex_job_request),
		.worker_idle     (worker_idle),
		.worker_job_valid(worker_job_valid),
		.worker_job_id   (worker_job_id),
		.worker_job_edges(worker_job_edges)
	);

	read_command_path cmd_path (
		.clock               (clock),
		.rstn                (rstn),
		.enabled             (enabled),
		.cmd_request         (cmd_request),
		.cmd_address         (cmd_address),
		.cmd_grant           (cmd_grant),
		.read_buffer_alfull  (read_buffer_alfull),
		.bus_grant           (read_command_bus_grant),
		.bus_request         (read_command_bus_request),
		.read_command_valid  (read_command_valid),
		.read_command_address(read_command_address),
		.read_command_cu_id  (read_command_cu_id)
	);

	////////////////////////////////////////////////////////////
	// Response routing by cu id
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			response_valid_r      <= 1'b0;
			worker_response_valid <= '0;
		end else begin
			response_valid_r <= enabled && read_response_valid;
			for (int k = 0; k < `NUM_CU; k++) begin
				worker_response_valid[k] <= response_valid_r && enable_mask[k]
					&& (response_cu_id_r == graph_pkg::cu_id_t'(k));
			end
		end
	end

	always_ff @(posedge clock) begin
		response_cu_id_r <= read_response_cu_id;
	end

	for (genvar i = 0; i < `NUM_CU; i++) begin : gen_worker
		vertex_worker #(
			.CU_ID(i)
		) worker (
			.clock         (clock),
			.rstn          (rstn),
			.enabled       (enable_mask[i]),
			.idle          (worker_idle[i]),
			.job_valid     (worker_job_valid[i]),
			.job_id        (worker_job_id),
			.job_edges     (worker_job_edges),
			.cmd_request   (cmd_request[i]),
			.cmd_address   (cmd_address[i]),
			.cmd_grant     (cmd_grant[i]),
			.response_valid(worker_response_valid[i]),
			.vertex_count  (vertex_count[i]),
			.edge_count    (edge_count[i])
		);
	end

	////////////////////////////////////////////////////////////
	// Done counters
	////////////////////////////////////////////////////////////

	always_comb begin
		vertex_sum = '0;
		edge_sum   = '0;
		for (int k = 0; k < `NUM_CU; k++) begin
			vertex_sum = vertex_sum + vertex_count[k];
			edge_sum   = edge_sum + edge_count[k];
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_job_counter_done <= '0;
			edge_job_counter_done   <= '0;
		end else if (enabled) begin
			vertex_job_counter_done <= vertex_sum;
			edge_job_counter_done   <= edge_sum;
		end
	end

	// Worker counts only grow, so the sums only grow
	done_monotonic: assert property (@(posedge clock) disable iff (!rstn)
		1'b1 |=> (vertex_job_counter_done >= $past(vertex_job_counter_done))
			&& (edge_job_counter_done >= $past(edge_job_counter_done)))
		else $error("done counter went down");

endmodule

//--- design/vertex_worker.sv
// Vertex worker

module vertex_worker #(
	parameter int CU_ID = 0
) (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   enabled,
	output logic                   idle,
	input  logic                   job_valid,
	input  graph_pkg::vertex_id_t  job_id,
	input  graph_pkg::edge_count_t job_edges,
	output logic                   cmd_request,
	output graph_pkg::vertex_id_t  cmd_address,
	input  logic                   cmd_grant,
	input  logic                   response_valid,
	output graph_pkg::counter_t    vertex_count,
	output graph_pkg::counter_t    edge_count
);

	graph_pkg::worker_state_e state;
	graph_pkg::edge_count_t   job_edges_r;

	// Not idle while a job strobe is arriving
	assign idle        = enabled && (state == graph_pkg::IDLE) && !job_valid;
	assign cmd_request = (state == graph_pkg::ISSUE);

	////////////////////////////////////////////////////////////
	// Worker FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state        <= graph_pkg::IDLE;
			vertex_count <= '0;
			edge_count   <= '0;
		end else begin
			case (state)
				graph_pkg::IDLE: begin
					if (job_valid) begin
						state <= graph_pkg::ISSUE;
					end
				end
				graph_pkg::ISSUE: begin
					// Request held until the arbiter picks us
					if (cmd_grant) begin
						state <= graph_pkg::WAIT;
					end
				end
				graph_pkg::WAIT: begin
					if (response_valid) begin
						state        <= graph_pkg::IDLE;
						vertex_count <= vertex_count + 1'b1;
						edge_count   <= edge_count + graph_pkg::counter_t'(job_edges_r);
					end
				end
				default: begin
					state <= graph_pkg::IDLE;
				end
			endcase
		end
	end

	// Job fields for the read and the edge count
	always_ff @(posedge clock) begin
		if ((state == graph_pkg::IDLE) && job_valid) begin
			cmd_address <= job_id;
			job_edges_r <= job_edges;
		end
	end

	job_when_idle: assert property (@(posedge clock) disable iff (!rstn)
		job_valid |-> (state == graph_pkg::IDLE))
		else $error("worker %0d got a job while busy", CU_ID);

	response_when_waiting: assert property (@(posedge clock) disable iff (!rstn)
		response_valid |-> (state == graph_pkg::WAIT))
		else $error("worker %0d got a response it did not ask for", CU_ID);

endmodule

//--- design/read_command_path.sv
// Read command arbitration and burst buffer
`include "graph_consts.svh"

module read_command_path (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  enabled,
	input  graph_pkg::cu_mask_t   cmd_request,
	input  graph_pkg::vertex_id_t cmd_address [`NUM_CU],
	output graph_pkg::cu_mask_t   cmd_grant,
	input  logic                  read_buffer_alfull,
	input  logic                  bus_grant,
	output logic                  bus_request,
	output logic                  read_command_valid,
	output graph_pkg::vertex_id_t read_command_address,
	output graph_pkg::cu_id_t     read_command_cu_id
);

	localparam int CMD_W = $bits(graph_pkg::cu_id_t) + $bits(graph_pkg::vertex_id_t);

	graph_pkg::cu_id_t     winner;
	logic                  push_valid;
	graph_pkg::cu_id_t     push_cu_id;
	graph_pkg::vertex_id_t push_address;
	logic [CMD_W-1:0]      burst_head;
	logic                  burst_empty;
	logic                  burst_almost_full;
	logic                  bus_grant_r;
	logic                  burst_pop;

	////////////////////////////////////////////////////////////
	// Worker command arbitration
	////////////////////////////////////////////////////////////

	rr_arbiter #(
		.NUM_REQUESTS(`NUM_CU)
	) cmd_arbiter (
		.clock   (clock),
		.rstn    (rstn),
		.enable  (enabled && !burst_almost_full),
		.requests(cmd_request),
		.grant   (cmd_grant)
	);

	// One-hot grant to worker id
	always_comb begin
		winner = '0;
		for (int k = 0; k < `NUM_CU; k++) begin
			if (cmd_grant[k]) begin
				winner = graph_pkg::cu_id_t'(k);
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			push_valid <= 1'b0;
		end else begin
			push_valid <= |cmd_grant;
		end
	end

	// Tag the command with the id of its worker
	always_ff @(posedge clock) begin
		if (|cmd_grant) begin
			push_cu_id   <= winner;
			push_address <= cmd_address[winner];
		end
	end

	sync_fifo #(
		.WIDTH(CMD_W),
		.DEPTH(`CMD_FIFO_DEPTH)
	) burst_fifo (
		.clock      (clock),
		.rstn       (rstn),
		.push       (push_valid),
		.data_in    ({push_cu_id, push_address}),
		.pop        (bus_grant_r),
		.data_out   (burst_head),
		.empty      (burst_empty),
		.full       (),
		.almost_full(burst_almost_full)
	);

	////////////////////////////////////////////////////////////
	// Bus request and grant
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			bus_request <= 1'b0;
			bus_grant_r <= 1'b0;
		end else if (enabled) begin
			bus_request <= !burst_empty && !read_buffer_alfull;
			bus_grant_r <= bus_grant;
		end
	end

	// Grant on an empty buffer pops nothing
	assign burst_pop = bus_grant_r && !burst_empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_command_valid <= 1'b0;
		end else begin
			read_command_valid <= burst_pop;
		end
	end

	always_ff @(posedge clock) begin
		if (burst_pop) begin
			{read_command_cu_id, read_command_address} <= burst_head;
		end
	end

endmodule

//--- design/vertex_job_dispatch.sv
// Vertex job dispatch
`include "graph_consts.svh"

module vertex_job_dispatch (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   enabled,
	input  logic                   job_valid,
	input  graph_pkg::vertex_id_t  job_id,
	input  graph_pkg::edge_count_t job_edges,
	output logic                   job_request,
	input  graph_pkg::cu_mask_t    worker_idle,
	output graph_pkg::cu_mask_t    worker_job_valid,
	output graph_pkg::vertex_id_t  worker_job_id,
	output graph_pkg::edge_count_t worker_job_edges
);

	localparam int JOB_W = $bits(graph_pkg::vertex_id_t) + $bits(graph_pkg::edge_count_t);

	logic [JOB_W-1:0]    head_job;
	logic                job_empty;
	logic                job_almost_full;
	logic                job_pop;
	graph_pkg::cu_mask_t job_grant;

	// Keep asking while a push in flight still fits
	assign job_request = !job_almost_full;
	assign job_pop     = |job_grant;

	sync_fifo #(
		.WIDTH(JOB_W),
		.DEPTH(`JOB_FIFO_DEPTH)
	) job_fifo (
		.clock      (clock),
		.rstn       (rstn),
		.push       (job_valid),
		.data_in    ({job_id, job_edges}),
		.pop        (job_pop),
		.data_out   (head_job),
		.empty      (job_empty),
		.full       (),
		.almost_full(job_almost_full)
	);

	////////////////////////////////////////////////////////////
	// Hand the head job to one idle worker
	////////////////////////////////////////////////////////////

	rr_arbiter #(
		.NUM_REQUESTS(`NUM_CU)
	) job_arbiter (
		.clock   (clock),
		.rstn    (rstn),
		.enable  (enabled && !job_empty),
		.requests(worker_idle),
		.grant   (job_grant)
	);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			worker_job_valid <= '0;
		end else begin
			worker_job_valid <= job_grant;
		end
	end

	// Job fields go to every worker, the valid picks one
	always_ff @(posedge clock) begin
		if (job_pop) begin
			{worker_job_id, worker_job_edges} <= head_job;
		end
	end

endmodule

//--- design/rr_arbiter.sv
// Round-robin arbiter

module rr_arbiter #(
	parameter int NUM_REQUESTS = 4
) (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    enable,
	input  logic [NUM_REQUESTS-1:0] requests,
	output logic [NUM_REQUESTS-1:0] grant
);

	localparam int IDX_W = (NUM_REQUESTS > 1) ? $clog2(NUM_REQUESTS) : 1;

	logic [IDX_W-1:0] last_winner;
	logic [IDX_W-1:0] winner;

	// Search starts one past the last winner
	always_comb begin
		int idx;
		idx    = 0;
		grant  = '0;
		winner = last_winner;
		if (enable) begin
			for (int offset = 1; offset <= NUM_REQUESTS; offset++) begin
				idx = (int'(last_winner) + offset) % NUM_REQUESTS;
				if (requests[idx] && (grant == '0)) begin
					grant[idx] = 1'b1;
					winner     = IDX_W'(idx);
				end
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			// Request 0 wins first
			last_winner <= IDX_W'(NUM_REQUESTS - 1);
		end else if (|grant) begin
			last_winner <= winner;
		end
	end

	grant_onehot: assert property (@(posedge clock) disable iff (!rstn) $onehot0(grant))
		else $error("arbiter granted more than one request");

endmodule

//--- design/sync_fifo.sv
// Synchronous FIFO

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 8
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             empty,
	output logic             full,
	output logic             almost_full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign empty = (count == '0);
	assign full  = (count == CNT_W'(DEPTH));
	// Two or fewer free slots, room for one push in flight
	assign almost_full = (count >= CNT_W'(DEPTH - 2));

	// Head entry is visible without a pop
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	push_when_full: assert property (@(posedge clock) disable iff (!rstn) push |-> !full)
		else $error("push into a full FIFO");

endmodule

//--- design/graph_pkg.sv
// Graph control types
`include "graph_consts.svh"

package graph_pkg;

	typedef logic [`CU_ID_W-1:0] cu_id_t;

	typedef logic [`VERTEX_ID_W-1:0] vertex_id_t;

	typedef logic [`EDGE_COUNT_W-1:0] edge_count_t;

	typedef logic [`COUNTER_W-1:0] counter_t;

	// One bit per worker
	typedef logic [`NUM_CU-1:0] cu_mask_t;

	// Worker FSM
	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		WAIT
	} worker_state_e;

endpackage

//--- design/graph_consts.svh
// Graph control constants
`ifndef GRAPH_CONSTS_SVH
`define GRAPH_CONSTS_SVH

////////////////////////////////////////////////////////////
// Worker array
////////////////////////////////////////////////////////////

`define NUM_CU 4
`define CU_ID_W 2

////////////////////////////////////////////////////////////
// Job and counter widths
////////////////////////////////////////////////////////////

// Vertex id doubles as the read address
`define VERTEX_ID_W 16
`define EDGE_COUNT_W 8
`define COUNTER_W 32

// Buffer depths
`define JOB_FIFO_DEPTH 8
`define CMD_FIFO_DEPTH 8

// Configure word, low field holds the active worker count
`define CONFIG_W 64
`define CU_COUNT_W 32

`endif
